/* verilog/bpb_pkg.sv */
package bpb_pkg;

    // #########################################################
    // address and counter types
    // #########################################################

    typedef logic [31:0] word_t;  // instruction address or branch target

    // two-bit branch state, only the upper bit predicts taken
    typedef enum logic [1:0]
    {
        COUNTER_NT      = 2'b00,  // strongly not taken
        COUNTER_WEAK    = 2'b01,  // one taken seen, still predicts not taken
        COUNTER_WEAK_NT = 2'b10,  // one miss after taken, still predicts taken
        COUNTER_T       = 2'b11   // strongly taken
    } counter_t;

    // #########################################################
    // default geometry
    // #########################################################

    localparam int DEFAULT_ENTRY_WIDTH = 4;  // index bits, 16 lines

    localparam int FETCH_WIDTH = 2;  // dual issue fetch slots

    localparam int PC_ALIGN_BITS = 2;  // byte offset of a word aligned pc

endpackage

/* verilog/bpb_line.sv */
`timescale 1ns/1ns

module bpb_line
#(
    parameter int ENTRY_WIDTH = bpb_pkg::DEFAULT_ENTRY_WIDTH
)
(
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  bpb_pkg::word_t [bpb_pkg::FETCH_WIDTH - 1:0] pc_predict,
    input  bpb_pkg::word_t pc_commit,
    input  logic wen,
    input  logic commit_taken,
    input  bpb_pkg::word_t commit_destpc,
    output logic [bpb_pkg::FETCH_WIDTH - 1:0] hit_predict,
    output logic [bpb_pkg::FETCH_WIDTH - 1:0] taken_predict,
    output bpb_pkg::word_t destpc_predict
);

    localparam int ADDR_WIDTH = $bits(bpb_pkg::word_t);
    localparam int TAG_LSB = bpb_pkg::PC_ALIGN_BITS + ENTRY_WIDTH;
    localparam int TAG_WIDTH = ADDR_WIDTH - TAG_LSB;

    logic valid;
    logic [TAG_WIDTH - 1:0] tag;
    bpb_pkg::word_t target;
    bpb_pkg::counter_t state;
    bpb_pkg::counter_t state_next;
    logic [TAG_WIDTH - 1:0] tag_commit;
    logic line_write;
    logic allocate;

    assign tag_commit = pc_commit[ADDR_WIDTH - 1:TAG_LSB];
    assign line_write = wen && !stall;  // stall blocks every write
    assign allocate = !valid || (tag != tag_commit);  // empty line or another branch

    // #########################################################
    // update side
    // #########################################################

    always_comb
    begin
        unique case (state)
            bpb_pkg::COUNTER_NT:      state_next = commit_taken ? bpb_pkg::COUNTER_WEAK
                                                                : bpb_pkg::COUNTER_NT;
            bpb_pkg::COUNTER_WEAK:    state_next = commit_taken ? bpb_pkg::COUNTER_T
                                                                : bpb_pkg::COUNTER_NT;
            bpb_pkg::COUNTER_WEAK_NT: state_next = commit_taken ? bpb_pkg::COUNTER_T
                                                                : bpb_pkg::COUNTER_NT;
            default:                  state_next = commit_taken ? bpb_pkg::COUNTER_T
                                                                : bpb_pkg::COUNTER_WEAK_NT;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid <= 1'b0;
        else if (line_write)
            valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (line_write)
        begin
            if (allocate)
            begin
                tag <= tag_commit;
                target <= commit_destpc;
                state <= bpb_pkg::COUNTER_NT;  // new branch starts not taken
            end
            else
                state <= state_next;
        end
    end

    // #########################################################
    // lookup side, one compare per fetch slot
    // #########################################################

    genvar s;
    generate
        for (s = 0; s < bpb_pkg::FETCH_WIDTH; s++)
        begin : g_slot
            assign hit_predict[s] = valid && (tag == pc_predict[s][ADDR_WIDTH - 1:TAG_LSB]);
            assign taken_predict[s] = hit_predict[s] && state[1];  // upper bit only
        end
    endgenerate

    assign destpc_predict = target;  // same target for both slots

endmodule

/* verilog/bpb_bank.sv */
`timescale 1ns/1ns

module bpb_bank
#(
    parameter int ENTRY_WIDTH = bpb_pkg::DEFAULT_ENTRY_WIDTH
)
(
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  bpb_pkg::word_t [bpb_pkg::FETCH_WIDTH - 1:0] pc_predict,
    input  logic commit_wen,
    input  bpb_pkg::word_t commit_pc,
    input  logic commit_taken,
    input  bpb_pkg::word_t commit_destpc,
    output logic [bpb_pkg::FETCH_WIDTH - 1:0] hit_predict,
    output logic [bpb_pkg::FETCH_WIDTH - 1:0] taken_predict,
    output bpb_pkg::word_t [bpb_pkg::FETCH_WIDTH - 1:0] destpc_predict
);

    localparam int LINES = 1 << ENTRY_WIDTH;
    localparam int INDEX_LSB = bpb_pkg::PC_ALIGN_BITS;

    logic [ENTRY_WIDTH - 1:0] commit_index;
    logic [LINES - 1:0] line_wen;
    logic [bpb_pkg::FETCH_WIDTH - 1:0] line_hit [LINES];
    logic [bpb_pkg::FETCH_WIDTH - 1:0] line_taken [LINES];
    bpb_pkg::word_t line_destpc [LINES];
    logic [ENTRY_WIDTH - 1:0] slot_index [bpb_pkg::FETCH_WIDTH];

    // #########################################################
    // commit index decode
    // #########################################################

    assign commit_index = commit_pc[INDEX_LSB +: ENTRY_WIDTH];

    always_comb
    begin
        line_wen = '0;
        line_wen[commit_index] = commit_wen;  // one hot, or none
    end

    // #########################################################
    // line array
    // #########################################################

    genvar i;
    generate
        for (i = 0; i < LINES; i++)
        begin : g_line
            bpb_line
            #(
                .ENTRY_WIDTH(ENTRY_WIDTH)
            )
            u_line
            (
                .clk(clk),
                .reset(reset),
                .stall(stall),
                .pc_predict(pc_predict),
                .pc_commit(commit_pc),
                .wen(line_wen[i]),
                .commit_taken(commit_taken),
                .commit_destpc(commit_destpc),
                .hit_predict(line_hit[i]),
                .taken_predict(line_taken[i]),
                .destpc_predict(line_destpc[i])
            );
        end
    endgenerate

    // #########################################################
    // per slot read select
    // #########################################################

    // each slot reads the line named by its own index and takes that
    // line's compare result for the same slot
    genvar s;
    generate
        for (s = 0; s < bpb_pkg::FETCH_WIDTH; s++)
        begin : g_slot
            assign slot_index[s] = pc_predict[s][INDEX_LSB +: ENTRY_WIDTH];
            assign hit_predict[s] = line_hit[slot_index[s]][s];
            assign taken_predict[s] = line_taken[slot_index[s]][s];
            assign destpc_predict[s] = line_destpc[slot_index[s]];
        end
    endgenerate

endmodule

/* verilog/branch_resolve.sv */
`timescale 1ns/1ns

module branch_resolve
(
    input  logic clk,
    input  logic reset,
    input  logic ex_valid,
    input  bpb_pkg::word_t ex_pc,
    input  logic ex_taken,
    input  bpb_pkg::word_t ex_target,
    input  logic ex_pred_taken,
    input  bpb_pkg::word_t ex_pred_target,
    output logic mispredict,
    output bpb_pkg::word_t redirect_pc,
    output logic commit_wen,
    output bpb_pkg::word_t commit_pc,
    output logic commit_taken,
    output bpb_pkg::word_t commit_destpc
);

    localparam bpb_pkg::word_t DELAY_SLOT_OFFSET = 32'd8;  // branch plus delay slot

    logic wrong_direction;
    logic wrong_target;
    logic mispredict_next;
    bpb_pkg::word_t redirect_next;

    // #########################################################
    // outcome against prediction
    // #########################################################

    assign wrong_direction = ex_taken != ex_pred_taken;
    assign wrong_target = ex_taken && (ex_target != ex_pred_target);  // taken only
    assign mispredict_next = ex_valid && (wrong_direction || wrong_target);

    // not taken resumes after the delay slot
    assign redirect_next = ex_taken ? ex_target : (ex_pc + DELAY_SLOT_OFFSET);

    // #########################################################
    // output registers
    // #########################################################

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mispredict <= 1'b0;
            commit_wen <= 1'b0;
        end
        else
        begin
            mispredict <= mispredict_next;
            commit_wen <= ex_valid;  // every resolved branch trains the buffer
        end
    end

    always_ff @(posedge clk)
    begin
        redirect_pc <= redirect_next;  // read only with mispredict
        commit_pc <= ex_pc;
        commit_taken <= ex_taken;
        commit_destpc <= ex_target;
    end

endmodule

/* verilog/branch_predictor.sv */
`timescale 1ns/1ns

module branch_predictor
#(
    parameter int ENTRY_WIDTH = bpb_pkg::DEFAULT_ENTRY_WIDTH
)
(
    input  logic clk,
    input  logic reset,
    input  logic stall,

    // fetch side
    input  bpb_pkg::word_t [bpb_pkg::FETCH_WIDTH - 1:0] pc_predict,
    output logic [bpb_pkg::FETCH_WIDTH - 1:0] hit_predict,
    output logic [bpb_pkg::FETCH_WIDTH - 1:0] taken_predict,
    output bpb_pkg::word_t [bpb_pkg::FETCH_WIDTH - 1:0] destpc_predict,

    // execute side
    input  logic ex_valid,
    input  bpb_pkg::word_t ex_pc,
    input  logic ex_taken,
    input  bpb_pkg::word_t ex_target,
    input  logic ex_pred_taken,
    input  bpb_pkg::word_t ex_pred_target,
    output logic mispredict,
    output bpb_pkg::word_t redirect_pc
);

    logic commit_wen;
    bpb_pkg::word_t commit_pc;
    logic commit_taken;
    bpb_pkg::word_t commit_destpc;

    // #########################################################
    // resolution stage, one cycle behind execute
    // #########################################################

    branch_resolve u_resolve
    (
        .clk(clk),
        .reset(reset),
        .ex_valid(ex_valid),
        .ex_pc(ex_pc),
        .ex_taken(ex_taken),
        .ex_target(ex_target),
        .ex_pred_taken(ex_pred_taken),
        .ex_pred_target(ex_pred_target),
        .mispredict(mispredict),
        .redirect_pc(redirect_pc),
        .commit_wen(commit_wen),
        .commit_pc(commit_pc),
        .commit_taken(commit_taken),
        .commit_destpc(commit_destpc)
    );

    // #########################################################
    // prediction buffer
    // #########################################################

    bpb_bank
    #(
        .ENTRY_WIDTH(ENTRY_WIDTH)
    )
    u_bank
    (
        .clk(clk),
        .reset(reset),
        .stall(stall),  // write blocking only
        .pc_predict(pc_predict),
        .commit_wen(commit_wen),
        .commit_pc(commit_pc),
        .commit_taken(commit_taken),
        .commit_destpc(commit_destpc),
        .hit_predict(hit_predict),
        .taken_predict(taken_predict),
        .destpc_predict(destpc_predict)
    );

endmodule

/* dv/branch_predictor_properties.sv */
`timescale 1ns/1ns

module branch_predictor_properties
(
    input logic clk,
    input logic reset,
    input logic ex_valid,
    input logic mispredict,
    input logic commit_wen,
    input logic [bpb_pkg::FETCH_WIDTH - 1:0] hit_predict,
    input logic [bpb_pkg::FETCH_WIDTH - 1:0] taken_predict
);

    // registers and valid bits cleared by reset
    reset_quiet: assert property (@(posedge clk)
        reset |=> (!commit_wen && !mispredict && (hit_predict == '0)))
        else $error("commit, mispredict or hit active during or right after reset");

    mispredict_cause: assert property (@(posedge clk) disable iff (reset)
        mispredict |-> $past(ex_valid))  // one cycle behind execute
        else $error("mispredict without a resolved branch one cycle earlier");

    taken_needs_hit: assert property (@(posedge clk) disable iff (reset)
        (taken_predict & ~hit_predict) == '0)
        else $error("taken prediction on a slot that did not hit");

endmodule

bind branch_predictor branch_predictor_properties u_properties
(
    .clk(clk),
    .reset(reset),
    .ex_valid(ex_valid),
    .mispredict(mispredict),
    .commit_wen(commit_wen),  // internal commit strobe
    .hit_predict(hit_predict),
    .taken_predict(taken_predict)
);

/* dv/branch_predictor_tb.sv */
`timescale 1ns/1ns

module branch_predictor_tb;

    localparam int ENTRY_WIDTH = 2;  // four lines, easy tag conflicts
    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY = 2;  // inputs change after the edge
    localparam int MAX_LINES = 64;

    // column layout of one golden line
    localparam int F_STALL = 0;
    localparam int F_EX_VALID = 1;
    localparam int F_EX_TAKEN = 2;
    localparam int F_EX_PC = 3;
    localparam int F_EX_TARGET = 4;
    localparam int F_PRED_TAKEN = 5;
    localparam int F_PRED_TARGET = 6;
    localparam int F_PC = 7;  // one column per slot
    localparam int F_HIT = 9;
    localparam int F_TAKEN = 10;
    localparam int F_DEST = 11;  // one column per slot
    localparam int F_MISPREDICT = 13;
    localparam int F_REDIRECT = 14;
    localparam int FIELDS = 15;
    localparam int MEM_WORDS = FIELDS * MAX_LINES;

    logic clk;
    logic reset;
    logic stall;
    bpb_pkg::word_t [bpb_pkg::FETCH_WIDTH - 1:0] pc_predict;
    logic [bpb_pkg::FETCH_WIDTH - 1:0] hit_predict;
    logic [bpb_pkg::FETCH_WIDTH - 1:0] taken_predict;
    bpb_pkg::word_t [bpb_pkg::FETCH_WIDTH - 1:0] destpc_predict;
    logic ex_valid;
    bpb_pkg::word_t ex_pc;
    logic ex_taken;
    bpb_pkg::word_t ex_target;
    logic ex_pred_taken;
    bpb_pkg::word_t ex_pred_target;
    logic mispredict;
    bpb_pkg::word_t redirect_pc;

    bpb_pkg::word_t golden [MEM_WORDS];
    int num_lines;
    int current_line;
    logic loaded;

    branch_predictor
    #(
        .ENTRY_WIDTH(ENTRY_WIDTH)
    )
    dut
    (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .pc_predict(pc_predict),
        .hit_predict(hit_predict),
        .taken_predict(taken_predict),
        .destpc_predict(destpc_predict),
        .ex_valid(ex_valid),
        .ex_pc(ex_pc),
        .ex_taken(ex_taken),
        .ex_target(ex_target),
        .ex_pred_taken(ex_pred_taken),
        .ex_pred_target(ex_pred_target),
        .mispredict(mispredict),
        .redirect_pc(redirect_pc)
    );

    // ########################################################
    // clock and watchdog
    // ########################################################

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        wait (loaded);
        #((RESET_CYCLES + num_lines + 20) * CLK_PERIOD);  // margin past the last line
        $display("watchdog expired before the stimulus finished");
        $display("tests failed");
        $fatal(1, "simulation timeout");
    end

    // ########################################################
    // helpers
    // ########################################################

    task automatic check_value(input string name, input bpb_pkg::word_t actual,
                               input bpb_pkg::word_t expected);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h (golden line %0d)",
                     $time, name, actual, expected, current_line);
            $display("tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic load_golden();
        for (int a = 0; a < MEM_WORDS; a++)
            golden[a] = 32'hdead_0000 ^ bpb_pkg::word_t'(a);  // unloaded words stay above 1
        $readmemh("dv/bpb_golden.txt", golden);
        num_lines = 0;
        while (num_lines < MAX_LINES && golden[num_lines * FIELDS] <= 1)
            num_lines++;
        loaded = 1'b1;
    endtask

    task automatic drive_line(input int n);
        int base;
        base = n * FIELDS;
        stall = golden[base + F_STALL][0];
        ex_valid = golden[base + F_EX_VALID][0];
        ex_taken = golden[base + F_EX_TAKEN][0];
        ex_pc = golden[base + F_EX_PC];
        ex_target = golden[base + F_EX_TARGET];
        ex_pred_taken = golden[base + F_PRED_TAKEN][0];
        ex_pred_target = golden[base + F_PRED_TARGET];
        for (int s = 0; s < bpb_pkg::FETCH_WIDTH; s++)
            pc_predict[s] = golden[base + F_PC + s];
    endtask

    task automatic check_line(input int n);
        int base;
        logic [1:0] exp_hit;
        logic [1:0] exp_taken;
        logic exp_mispredict;
        base = n * FIELDS;
        exp_hit = golden[base + F_HIT][1:0];
        exp_taken = golden[base + F_TAKEN][1:0];
        exp_mispredict = golden[base + F_MISPREDICT][0];
        check_value("hit_predict", 32'(hit_predict), 32'(exp_hit));
        check_value("taken_predict", 32'(taken_predict), 32'(exp_taken));
        for (int s = 0; s < bpb_pkg::FETCH_WIDTH; s++)
        begin
            if (exp_hit[s])  // target only means something on a hit
                check_value($sformatf("destpc_predict[%0d]", s), destpc_predict[s],
                            golden[base + F_DEST + s]);
        end
        check_value("mispredict", 32'(mispredict), 32'(exp_mispredict));
        if (exp_mispredict)
            check_value("redirect_pc", redirect_pc, golden[base + F_REDIRECT]);
    endtask

    // ########################################################
    // stimulus
    // ########################################################

    initial
    begin
        loaded = 1'b0;
        current_line = 0;
        reset = 1'b1;
        stall = 1'b0;
        pc_predict = '0;
        ex_valid = 1'b0;
        ex_pc = '0;
        ex_taken = 1'b0;
        ex_target = '0;
        ex_pred_taken = 1'b0;
        ex_pred_target = '0;
        load_golden();
        if (num_lines == 0)
        begin
            $display("no stimulus lines found in dv/bpb_golden.txt");
            $display("tests failed");
            $fatal(1, "empty golden file");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        for (int n = 0; n < num_lines; n++)
        begin
            current_line = n;
            drive_line(n);
            @(negedge clk);  // mid cycle, outputs settled
            check_line(n);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        $display("all tests passed");
        $finish;
    end

endmodule

/* dv/bpb_golden.txt */
// stall ex_valid ex_taken ex_pc ex_target ex_pred_taken ex_pred_target pc0 pc1
//   expected: hit taken destpc0 destpc1 mispredict redirect_pc (hex, one line per cycle)
0 0 0 00000000 00000000 0 00000000 00000104 00000204 0 0 00000000 00000000 0 00000000
0 0 0 00000000 00000000 0 00000000 00000308 00000010 0 0 00000000 00000000 0 00000000
0 1 1 00000104 00000400 0 00000000 00000104 00000104 0 0 00000000 00000000 0 00000000
0 0 0 00000000 00000000 0 00000000 00000104 00000104 0 0 00000000 00000000 1 00000400
0 1 1 00000104 00000400 0 00000000 00000104 00000104 3 0 00000400 00000400 0 00000000
0 1 1 00000104 00000400 0 00000000 00000104 00000000 1 0 00000400 00000000 1 00000400
0 0 0 00000000 00000000 0 00000000 00000104 00000104 3 0 00000400 00000400 1 00000400
0 1 0 00000104 00000400 1 00000400 00000104 00000104 3 3 00000400 00000400 0 00000000
0 1 0 00000104 00000400 1 00000400 00000104 00000104 3 3 00000400 00000400 1 0000010c
0 0 0 00000000 00000000 0 00000000 00000104 00000104 3 3 00000400 00000400 1 0000010c
0 0 0 00000000 00000000 0 00000000 00000104 00000104 3 0 00000400 00000400 0 00000000
0 1 1 00000204 00000600 0 00000000 00000104 00000204 1 0 00000400 00000000 0 00000000
0 0 0 00000000 00000000 0 00000000 00000104 00000204 1 0 00000400 00000000 1 00000600
0 0 0 00000000 00000000 0 00000000 00000104 00000204 2 0 00000000 00000600 0 00000000
0 1 1 00000204 00000600 1 00000700 00000204 00000104 1 0 00000600 00000000 0 00000000
0 1 0 00000010 00000800 0 00000000 00000204 00000010 1 0 00000600 00000000 1 00000600
0 0 0 00000000 00000000 0 00000000 00000010 00000204 2 0 00000000 00000600 0 00000000
0 1 1 00000308 00000900 1 00000900 00000308 00000204 2 0 00000000 00000600 0 00000000
1 1 1 00000308 00000900 1 00000900 00000308 00000204 2 0 00000000 00000600 0 00000000
1 1 1 00000308 00000900 1 00000900 00000308 00000204 2 0 00000000 00000600 0 00000000
0 0 0 00000000 00000000 0 00000000 00000308 00000204 2 0 00000000 00000600 0 00000000
0 0 0 00000000 00000000 0 00000000 00000308 00000204 3 0 00000900 00000600 0 00000000

/* sources.f */
verilog/bpb_pkg.sv
verilog/bpb_line.sv
verilog/bpb_bank.sv
verilog/branch_resolve.sv
verilog/branch_predictor.sv
dv/branch_predictor_properties.sv
dv/branch_predictor_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_branch_predictor
LOG_FILE=sim.log
FAIL_TEXT="tests failed"

verilator --binary --timing --assert \
    --top-module branch_predictor_tb \
    -f sources.f \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "run_sim: Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "$FAIL_TEXT" "$LOG_FILE"; then
    echo "run_sim: failure reported in $LOG_FILE"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "run_sim: simulation exited with status $run_status"
    exit 1
fi
echo "run_sim: no failure found in $LOG_FILE"
exit 0
